// File: filelist.f
+incdir+tb
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/fetch.sv
logic/control.sv
logic/decode.sv
logic/execute.sv
logic/dataMem.sv
logic/proc.sv
tb/tbProc.sv

// File: logic/control.sv
// Main decoder that turns an instruction into the control bundle and flags undefined opcodes
`default_nettype none

module control (
    input  wire isaPkg::instrT instr,
    output ctrlPkg::ctrlT      ctrl,
    output logic               illegal
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        ctrl    = CTRL_NOP;
        illegal = 1'b0;
        case (instr.opcode)
            OP_HALT: ctrl.halt = 1'b1;
            OP_NOP: ;
            OP_RFMT: begin
                ctrl.regWrite = 1'b1;
                ctrl.dstSel   = DST_RC;
                case (instr.low)
                    FN_ADD:  ctrl.aluOp = ALU_ADD;
                    FN_SUB:  ctrl.aluOp = ALU_SUB;
                    FN_XOR:  ctrl.aluOp = ALU_XOR;
                    FN_ANDN: ctrl.aluOp = ALU_ANDN;
                    default: ctrl.aluOp = ALU_ADD;
                endcase
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                // Low two opcode bits follow the ALU encoding
                ctrl.aluOp    = aluOpT'(instr.opcode[1:0]);
            end
            OP_LBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.dstSel   = DST_RA;
                ctrl.wbSrc    = WB_IMM;
                ctrl.immKind  = IMM8;
            end
            OP_LD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.wbSrc    = WB_MEM;
            end
            OP_ST: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_BEQZ: begin
                ctrl.brKind  = BR_EQZ;
                ctrl.immKind = IMM8;
            end
            OP_BNEZ: begin
                ctrl.brKind  = BR_NEZ;
                ctrl.immKind = IMM8;
            end
            OP_BLTZ: begin
                ctrl.brKind  = BR_LTZ;
                ctrl.immKind = IMM8;
            end
            OP_BGEZ: begin
                ctrl.brKind  = BR_GEZ;
                ctrl.immKind = IMM8;
            end
            OP_J: begin
                ctrl.jump    = 1'b1;
                ctrl.immKind = IMM11;
            end
            OP_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.immKind  = IMM11;
                ctrl.regWrite = 1'b1;
                ctrl.dstSel   = DST_R7;
                ctrl.wbSrc    = WB_LINK;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/ctrlPkg.sv
// Datapath control bundle and the ALU, branch, immediate and writeback selector encodings
`default_nettype none

package ctrlPkg;

    typedef enum logic [1:0] {
        ALU_ADD  = 2'b00,
        ALU_SUB  = 2'b01,
        ALU_XOR  = 2'b10,
        ALU_ANDN = 2'b11
    } aluOpT;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQZ  = 3'd1,
        BR_NEZ  = 3'd2,
        BR_LTZ  = 3'd3,
        BR_GEZ  = 3'd4
    } brKindT;

    typedef enum logic [1:0] {
        IMM5  = 2'd0,
        IMM8  = 2'd1,
        IMM11 = 2'd2
    } immKindT;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2,
        WB_IMM  = 2'd3
    } wbSrcT;

    // Which instruction field names the destination register
    typedef enum logic [1:0] {
        DST_RB = 2'd0,
        DST_RC = 2'd1,
        DST_RA = 2'd2,
        DST_R7 = 2'd3
    } dstSelT;

    typedef struct packed {
        logic    regWrite;
        dstSelT  dstSel;
        logic    aluSrc;
        aluOpT   aluOp;
        logic    memRead;
        logic    memWrite;
        wbSrcT   wbSrc;
        brKindT  brKind;
        logic    jump;
        logic    halt;
        immKindT immKind;
    } ctrlT;

    // No writes, no branch, falls through to PC+2
    localparam ctrlT CTRL_NOP = '{
        regWrite: 1'b0,
        dstSel:   DST_RB,
        aluSrc:   1'b0,
        aluOp:    ALU_ADD,
        memRead:  1'b0,
        memWrite: 1'b0,
        wbSrc:    WB_ALU,
        brKind:   BR_NONE,
        jump:     1'b0,
        halt:     1'b0,
        immKind:  IMM5
    };

endpackage

`default_nettype wire

// File: logic/dataMem.sv
// Word-addressed data memory with combinational read, clocked write and an alignment check
`default_nettype none

module dataMem (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         memRead,
    input  wire logic         memWrite,
    input  wire logic         writeEnable,
    input  wire isaPkg::wordT addr,
    input  wire isaPkg::wordT wrData,
    output isaPkg::wordT      rdData,
    output logic              misaligned
);
    import isaPkg::*;

    wordT   mem [DMEM_DEPTH];
    memIdxT idx;

    // Byte address to word index
    assign idx = addr[8:1];

    // Loads and stores both need an even address
    assign misaligned = (memRead | memWrite) & addr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite && writeEnable) begin
            mem[idx] <= wrData;
        end
    end

    always_comb begin
        if (memRead) begin
            rdData = mem[idx];
        end else begin
            rdData = '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/decode.sv
// Register file with two combinational reads, destination select and immediate sign extension
`default_nettype none

module decode (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire isaPkg::instrT  instr,
    input  wire ctrlPkg::ctrlT  ctrl,
    input  wire logic           wbWe,
    input  wire isaPkg::regIdxT wbReg,
    input  wire isaPkg::wordT   wbData,
    output isaPkg::wordT        rs,
    output isaPkg::wordT        rt,
    output isaPkg::regIdxT      destReg,
    output isaPkg::wordT        imm
);
    import isaPkg::*;
    import ctrlPkg::*;

    wordT regs [NUM_REGS];
    wordT raw;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe) begin
            regs[wbReg] <= wbData;
        end
    end

    // rB is both the second R-format source and the ST data register
    assign rs = regs[instr.rA];
    assign rt = regs[instr.rB];

    always_comb begin
        case (ctrl.dstSel)
            DST_RB:  destReg = instr.rB;
            DST_RC:  destReg = instr.rC;
            DST_RA:  destReg = instr.rA;
            DST_R7:  destReg = LINK_REG;
            default: destReg = instr.rB;
        endcase
    end

    assign raw = instr;

    // All immediate forms are sign extended
    always_comb begin
        case (ctrl.immKind)
            IMM5:    imm = {{11{raw[4]}}, raw[4:0]};
            IMM8:    imm = {{8{raw[7]}}, raw[7:0]};
            IMM11:   imm = {{5{raw[10]}}, raw[10:0]};
            default: imm = {{11{raw[4]}}, raw[4:0]};
        endcase
    end

endmodule

`default_nettype wire

// File: logic/execute.sv
// ALU, branch condition test and next-PC selection for the single-cycle datapath
`default_nettype none

module execute (
    input  wire isaPkg::wordT  pc,
    input  wire isaPkg::wordT  rs,
    input  wire isaPkg::wordT  rt,
    input  wire isaPkg::wordT  imm,
    input  wire ctrlPkg::ctrlT ctrl,
    output isaPkg::wordT       aluRes,
    output isaPkg::wordT       nextPc
);
    import isaPkg::*;
    import ctrlPkg::*;

    wordT opA;
    wordT opB;
    wordT pcInc;
    wordT target;
    logic taken;

    // First operand is always the rA register
    assign opA = rs;
    assign opB = ctrl.aluSrc ? imm : rt;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: begin
                aluRes = opA + opB;
            end
            ALU_SUB: begin
                // Reversed order gives second minus first
                aluRes = opB - opA;
            end
            ALU_XOR: begin
                aluRes = opA ^ opB;
            end
            ALU_ANDN: begin
                aluRes = opA & ~opB;
            end
            default: begin
                aluRes = opA + opB;
            end
        endcase
    end

    // Branches test only the sign bit or the zero value of rs
    always_comb begin
        case (ctrl.brKind)
            BR_EQZ:  taken = (rs == '0);
            BR_NEZ:  taken = (rs != '0);
            BR_LTZ:  taken = rs[15];
            BR_GEZ:  taken = ~rs[15];
            default: taken = 1'b0;
        endcase
    end

    assign pcInc = pc + PC_STEP;

    // Branch and jump displacements are both relative to PC+2
    assign target = pcInc + imm;

    always_comb begin
        if (taken || ctrl.jump) begin
            nextPc = target;
        end else begin
            nextPc = pcInc;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch.sv
// Program counter and instruction memory, loaded through a port while reset is held
`default_nettype none

module fetch (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           loadEn,
    input  wire isaPkg::memIdxT loadAddr,
    input  wire isaPkg::wordT   loadData,
    input  wire logic           stop,
    input  wire isaPkg::wordT   nextPc,
    output isaPkg::wordT        pc,
    output isaPkg::instrT       instr,
    output logic                running
);
    import isaPkg::*;

    wordT   imem [IMEM_DEPTH];
    memIdxT rdIdx;
    logic   stopped;

    // Program image is only written during reset
    always_ff @(posedge clk) begin
        if (rst && loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    // Once a trap or HALT executes the PC freezes until the next reset
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            stopped <= 1'b0;
        end else if (!stopped) begin
            if (stop) begin
                stopped <= 1'b1;
            end else begin
                pc <= nextPc;
            end
        end
    end

    // PC bit 0 is always clear so bits 8 to 1 give the word index
    assign rdIdx   = pc[8:1];
    assign instr   = instrT'(imem[rdIdx]);
    assign running = ~stopped;

endmodule

`default_nettype wire

// File: logic/isaPkg.sv
// Instruction set types, field layout, opcode encodings and memory sizes shared by the core
`default_nettype none

package isaPkg;

    // Data words and byte addresses are both 16 bits
    typedef logic [15:0] wordT;
    typedef logic [2:0]  regIdxT;
    typedef logic [7:0]  memIdxT;

    localparam int NUM_REGS   = 8;
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    // One 16-bit instruction per step
    localparam wordT PC_STEP = 16'd2;

    // JAL return address register
    localparam regIdxT LINK_REG = 3'd7;

    // Opcode sits in instruction bits 15 to 11
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JAL   = 5'b00110,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_LBI   = 5'b11000,
        OP_RFMT  = 5'b11011
    } opcodeT;

    // R-format function in bits 1 to 0
    typedef enum logic [1:0] {
        FN_ADD  = 2'b00,
        FN_SUB  = 2'b01,
        FN_XOR  = 2'b10,
        FN_ANDN = 2'b11
    } functT;

    // Overlay of one instruction word, immediates are cut from the raw bits
    typedef struct packed {
        opcodeT opcode;
        regIdxT rA;
        regIdxT rB;
        regIdxT rC;
        functT  low;
    } instrT;

endpackage

`default_nettype wire

// File: logic/proc.sv
// Processor top that ties the datapath blocks together and exposes the retire trace and traps
`default_nettype none

module proc (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           loadEn,
    input  wire isaPkg::memIdxT loadAddr,
    input  wire isaPkg::wordT   loadData,
    output logic                retValid,
    output isaPkg::wordT        retPc,
    output logic                retWe,
    output isaPkg::regIdxT      retReg,
    output isaPkg::wordT        retData,
    output logic                halted,
    output logic                err
);
    import isaPkg::*;
    import ctrlPkg::*;

    wordT   pc, nextPc, rs, rt, imm, aluRes, rdData, wbData;
    instrT  instr;
    ctrlT   ctrl;
    regIdxT destReg;
    logic   illegal, misaligned, running, trap, wbWe, memWe;

    fetch fetch0 (.clk(clk), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr),
                  .loadData(loadData), .stop(trap), .nextPc(nextPc), .pc(pc),
                  .instr(instr), .running(running));

    control control0 (.instr(instr), .ctrl(ctrl), .illegal(illegal));

    decode decode0 (.clk(clk), .rst(rst), .instr(instr), .ctrl(ctrl), .wbWe(wbWe),
                    .wbReg(destReg), .wbData(wbData), .rs(rs), .rt(rt),
                    .destReg(destReg), .imm(imm));

    execute exec0 (.pc(pc), .rs(rs), .rt(rt), .imm(imm), .ctrl(ctrl),
                   .aluRes(aluRes), .nextPc(nextPc));

    dataMem mem0 (.clk(clk), .rst(rst), .memRead(ctrl.memRead), .memWrite(ctrl.memWrite),
                  .writeEnable(memWe), .addr(aluRes), .wrData(rt), .rdData(rdData),
                  .misaligned(misaligned));

    // The trapping instruction still retires but its writes are dropped
    assign trap  = ctrl.halt | illegal | misaligned;
    assign wbWe  = ctrl.regWrite & running & ~trap;
    assign memWe = running & ~trap;

    always_comb begin
        case (ctrl.wbSrc)
            WB_ALU:  wbData = aluRes;
            WB_MEM:  wbData = rdData;
            WB_LINK: wbData = pc + PC_STEP;
            WB_IMM:  wbData = imm;
            default: wbData = aluRes;
        endcase
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (running) begin
            if (ctrl.halt) begin
                halted <= 1'b1;
            end
            if (illegal || misaligned) begin
                err <= 1'b1;
            end
        end
    end

    assign retValid = running;
    assign retPc    = pc;
    assign retWe    = wbWe;
    assign retReg   = destReg;
    assign retData  = wbData;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build with Verilator, run the testbench and look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module tbProc -o tbProc &&
./obj_dir/tbProc | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed" >&2; exit 1; }

// File: tb/isaModel.svh
// Reference ISA model included into the testbench body, steps one instruction on its own state
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

wordT mRegs [NUM_REGS];
wordT mMem [DMEM_DEPTH];
wordT mPc;

task automatic resetModel();
    for (int i = 0; i < NUM_REGS; i++) begin
        mRegs[i] = '0;
    end
    for (int i = 0; i < DMEM_DEPTH; i++) begin
        mMem[i] = '0;
    end
    mPc = '0;
endtask

function automatic logic opcodeDefined(input logic [4:0] op);
    case (op)
        OP_HALT, OP_NOP, OP_J, OP_JAL, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
        OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ, OP_ST, OP_LD, OP_LBI, OP_RFMT: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Kind 0 add, 1 second minus first, 2 xor, 3 first and not second
function automatic wordT applyAlu(input logic [1:0] kind, input wordT x, input wordT y);
    case (kind)
        2'd0: return x + y;
        2'd1: return y - x;
        2'd2: return x ^ y;
        default: return x & ~y;
    endcase
endfunction

task automatic executeModel(input wordT ins, output logic we, output regIdxT rd,
                            output wordT data, output logic stop, output logic trapErr);
    logic [4:0] op;
    logic       taken;
    wordT       a;
    wordT       s5;
    wordT       s8;
    wordT       s11;
    wordT       addr;
    wordT       nxt;
    op = ins[15:11];
    a = mRegs[ins[10:8]];
    s5 = {{11{ins[4]}}, ins[4:0]};
    s8 = {{8{ins[7]}}, ins[7:0]};
    s11 = {{5{ins[10]}}, ins[10:0]};
    addr = a + s5;
    nxt = mPc + 16'd2;
    taken = 1'b0;
    we = 1'b0;
    rd = ins[7:5];
    data = '0;
    stop = 1'b0;
    trapErr = 1'b0;
    case (op)
        OP_HALT: stop = 1'b1;
        OP_NOP: ;
        OP_RFMT: begin
            we = 1'b1;
            rd = ins[4:2];
            data = applyAlu(ins[1:0], a, mRegs[ins[7:5]]);
        end
        OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            we = 1'b1;
            data = applyAlu(op == OP_ADDI ? 2'd0 : op == OP_SUBI ? 2'd1 :
                            op == OP_XORI ? 2'd2 : 2'd3, a, s5);
        end
        OP_LBI: begin
            we = 1'b1;
            rd = ins[10:8];
            data = s8;
        end
        OP_LD, OP_ST: begin
            if (addr[0]) begin
                stop = 1'b1;
                trapErr = 1'b1;
            end else if (op == OP_LD) begin
                we = 1'b1;
                data = mMem[addr[8:1]];
            end else begin
                mMem[addr[8:1]] = mRegs[ins[7:5]];
            end
        end
        OP_BEQZ: taken = (a == '0);
        OP_BNEZ: taken = (a != '0);
        OP_BLTZ: taken = a[15];
        OP_BGEZ: taken = ~a[15];
        OP_J: taken = 1'b1;
        OP_JAL: begin
            taken = 1'b1;
            we = 1'b1;
            rd = 3'd7;
            data = nxt;
        end
        default: begin
            stop = 1'b1;
            trapErr = 1'b1;
        end
    endcase
    // Targets are relative to the next sequential PC
    if (taken) begin
        nxt = nxt + ((op == OP_J || op == OP_JAL) ? s11 : s8);
    end
    if (!stop) begin
        if (we) begin
            mRegs[rd] = data;
        end
        mPc = nxt;
    end
endtask

`endif

// File: tb/tbProc.sv
// Self-checking testbench for the processor, runs random programs against the ISA model
`default_nettype none

module tbProc;
    import isaPkg::*;

    // Six loads of 257 cycles plus six runs of under 64 cycles stay below this
    localparam int CYCLE_LIMIT = 2000;
    localparam int IDLE_CYCLES = 4;

    logic        clk;
    logic        rst;
    logic        loadEn;
    memIdxT      loadAddr;
    wordT        loadData;
    logic        retValid;
    wordT        retPc;
    logic        retWe;
    regIdxT      retReg;
    wordT        retData;
    logic        halted;
    logic        err;
    logic [31:0] rngState;
    wordT        prog [IMEM_DEPTH];
    int          progLen;
    int          errorCount;
    int          checkCount;
    int          testsPassed;
    int          testsFailed;
    int          cycleCount;

    `include "isaModel.svh"

    proc dut0 (.clk(clk), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr),
               .loadData(loadData), .retValid(retValid), .retPc(retPc), .retWe(retWe),
               .retReg(retReg), .retData(retData), .halted(halted), .err(err));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: simulation reached %0d cycles without finishing", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int randBelow(input int n);
        return int'(nextRandom() % n);
    endfunction

    function automatic regIdxT randReg();
        return regIdxT'(randBelow(8));
    endfunction

    function automatic wordT encodeR(input logic [1:0] fn, input regIdxT ra, input regIdxT rb,
                                     input regIdxT rc);
        return {OP_RFMT, ra, rb, rc, fn};
    endfunction

    function automatic wordT encodeImm5(input opcodeT op, input regIdxT ra, input regIdxT rb,
                                        input logic [4:0] imm);
        return {op, ra, rb, imm};
    endfunction

    function automatic wordT encodeImm8(input opcodeT op, input regIdxT ra, input logic [7:0] imm);
        return {op, ra, imm};
    endfunction

    function automatic opcodeT pickImmOp();
        case (randBelow(4))
            0: return OP_ADDI;
            1: return OP_SUBI;
            2: return OP_XORI;
            default: return OP_ANDNI;
        endcase
    endfunction

    function automatic opcodeT pickBranchOp();
        case (randBelow(4))
            0: return OP_BEQZ;
            1: return OP_BNEZ;
            2: return OP_BLTZ;
            default: return OP_BGEZ;
        endcase
    endfunction

    task automatic checkValue(input string what, input wordT got, input wordT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic emit(input wordT w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic emitInitRegs();
        progLen = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            emit(encodeImm8(OP_LBI, regIdxT'(r), 8'(nextRandom())));
        end
    endtask

    task automatic emitRandomAlu();
        case (randBelow(3))
            0: emit(encodeR(2'(randBelow(4)), randReg(), randReg(), randReg()));
            1: emit(encodeImm5(pickImmOp(), randReg(), randReg(), 5'(nextRandom())));
            default: emit(encodeImm8(OP_LBI, randReg(), 8'(nextRandom())));
        endcase
    endtask

    // Words past the end decode as HALT with the address in the low bits
    task automatic finishProgram();
        emit({OP_HALT, 11'd0});
        for (int i = progLen; i < IMEM_DEPTH; i++) begin
            prog[i] = {OP_HALT, 3'd0, 8'(i)};
        end
    endtask

    task automatic buildAluProgram();
        emitInitRegs();
        for (int n = 0; n < 30; n++) begin
            emitRandomAlu();
        end
        finishProgram();
    endtask

    task automatic buildMemProgram();
        regIdxT     base;
        regIdxT     dataReg;
        logic [4:0] offset;
        emitInitRegs();
        // R0 to R3 hold even base addresses and loads only write R4 to R7
        for (int r = 0; r < 4; r++) begin
            emit(encodeImm8(OP_LBI, regIdxT'(r), 8'(nextRandom()) & 8'hfe));
        end
        for (int n = 0; n < 30; n++) begin
            base = regIdxT'(randBelow(4));
            dataReg = regIdxT'(4 + randBelow(4));
            offset = 5'(nextRandom()) & 5'h1e;
            case (randBelow(3))
                0: emit(encodeImm5(OP_ST, base, randReg(), offset));
                1: emit(encodeImm5(OP_LD, base, dataReg, offset));
                default: emit(encodeR(2'd0, dataReg, regIdxT'(4 + randBelow(4)), dataReg));
            endcase
        end
        finishProgram();
    endtask

    task automatic buildBranchProgram();
        int haltIdx;
        int remaining;
        int k;
        emitInitRegs();
        emit(encodeImm8(OP_LBI, 3'd0, 8'd0));
        haltIdx = progLen + 36;
        // Offsets only go forward and never past the final HALT
        while (progLen < haltIdx) begin
            remaining = haltIdx - progLen - 1;
            k = randBelow((remaining < 4 ? remaining : 4) + 1);
            case (randBelow(4))
                0: emit(encodeImm8(pickBranchOp(), randReg(), 8'(2 * k)));
                1: emit({randBelow(2) == 0 ? OP_J : OP_JAL, 11'(2 * k)});
                default: emitRandomAlu();
            endcase
        end
        finishProgram();
    endtask

    task automatic buildStopProgram(input int kind);
        logic [4:0] op;
        emitInitRegs();
        for (int n = 0; n < 6; n++) begin
            emitRandomAlu();
        end
        if (kind == 0) begin
            emit({OP_HALT, 11'(nextRandom())});
        end else if (kind == 1) begin
            op = 5'(nextRandom());
            while (opcodeDefined(op)) begin
                op = 5'(nextRandom());
            end
            emit({op, 11'(nextRandom())});
        end else begin
            // Odd base plus even offset gives an odd address
            emit(encodeImm8(OP_LBI, 3'd1, 8'(nextRandom()) | 8'h01));
            emit(encodeImm5(kind == 2 ? OP_LD : OP_ST, 3'd1, randReg(),
                            5'(nextRandom()) & 5'h1e));
        end
        // Must never retire
        for (int n = 0; n < 4; n++) begin
            emitRandomAlu();
        end
        finishProgram();
    endtask

    task automatic loadProgram();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(posedge clk);
            rst      <= 1'b1;
            loadEn   <= 1'b1;
            loadAddr <= memIdxT'(i);
            loadData <= prog[i];
        end
        @(posedge clk);
        rst      <= 1'b0;
        loadEn   <= 1'b0;
        loadAddr <= '0;
        loadData <= '0;
    endtask

    task automatic runProgram();
        wordT   pcBefore;
        logic   we;
        regIdxT rd;
        wordT   data;
        logic   stop;
        logic   trapErr;
        logic   done;
        resetModel();
        stop = 1'b0;
        trapErr = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (!retValid) begin
                errorCount++;
                $display("Processor stopped retiring at model PC %h before the model stopped",
                         mPc);
                done = 1'b1;
            end else begin
                pcBefore = mPc;
                executeModel(prog[mPc[8:1]], we, rd, data, stop, trapErr);
                checkValue("retPc", retPc, pcBefore);
                checkValue("retWe", wordT'(retWe), wordT'(we));
                if (we) begin
                    checkValue("retReg", wordT'(retReg), wordT'(rd));
                    checkValue("retData", retData, data);
                end
                checkValue("halted while running", wordT'(halted), '0);
                checkValue("err while running", wordT'(err), '0);
                done = stop;
            end
        end
        for (int n = 0; n < IDLE_CYCLES; n++) begin
            @(posedge clk);
            checkValue("retValid after stop", wordT'(retValid), '0);
            checkValue("halted after stop", wordT'(halted), wordT'(!trapErr));
            checkValue("err after stop", wordT'(err), wordT'(trapErr));
        end
    endtask

    task automatic reportTest(input int num, input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            testsPassed++;
            $display("Test %0d, %s: passed", num, name);
        end else begin
            testsFailed++;
            $display("Test %0d, %s: failed with %0d errors", num, name,
                     errorCount - errorsBefore);
        end
    endtask

    initial begin
        int mark;
        rst = 1'b1;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        rngState = 32'hbcedafa3;
        errorCount = 0;
        checkCount = 0;
        testsPassed = 0;
        testsFailed = 0;

        mark = errorCount;
        buildAluProgram();
        loadProgram();
        runProgram();
        reportTest(1, "ALU and LBI", mark);

        mark = errorCount;
        buildMemProgram();
        loadProgram();
        runProgram();
        reportTest(2, "LD and ST", mark);

        mark = errorCount;
        buildBranchProgram();
        loadProgram();
        runProgram();
        reportTest(3, "branches and jumps", mark);

        // Second program checks the restart from PC 0 after a halt
        mark = errorCount;
        buildStopProgram(0);
        loadProgram();
        runProgram();
        buildStopProgram(0);
        loadProgram();
        runProgram();
        reportTest(4, "HALT and restart", mark);

        mark = errorCount;
        buildStopProgram(1 + randBelow(3));
        loadProgram();
        runProgram();
        reportTest(5, "traps", mark);

        $display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
                 testsPassed, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
